//--- rtl/tcp_logger_cfg.svh
`ifndef TCP_LOGGER_CFG_SVH
`define TCP_LOGGER_CFG_SVH

// width of one network flit in bits.
`define TCP_LOGGER_FLIT_W 64

// number of records the log memory holds.
`define TCP_LOGGER_LOG_DEPTH 16

// address width of the log memory, log2 of the depth.
`define TCP_LOGGER_ADDR_W 4

// node id of this logger. It goes into the src field of forwarded headers.
`define TCP_LOGGER_NODE_ID 8'h21

// next node that logged packets are sent on to.
`define TCP_LOGGER_FWD_DST 8'h05

`endif

//--- rtl/tcp_logger_mem.sv
`timescale 1ns/1ns
`include "tcp_logger_cfg.svh"

module tcp_logger_mem (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        wr_val,
    input  tcp_logger_pkg::log_addr_t   wr_addr,
    input  tcp_logger_pkg::log_record_t wr_record,
    output logic                        wr_rdy,

    input  logic                        rd_val,
    input  tcp_logger_pkg::log_addr_t   rd_addr,
    output tcp_logger_pkg::log_record_t rd_data,
    output logic                        rd_data_val
);

    tcp_logger_pkg::log_record_t mem [`TCP_LOGGER_LOG_DEPTH];

    // one port, so the host read wins the cycle.
    assign wr_rdy = ~rd_val;

    always_ff @(posedge clk) begin
        if (wr_val && wr_rdy) begin
            mem[wr_addr] <= wr_record;
        end
        if (rd_val) begin
            rd_data <= mem[rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data_val <= 1'b0;
        end else begin
            rd_data_val <= rd_val;
        end
    end

    // the control must hold the TCP flit back while the host reads.
    a_no_wr_during_rd: assert property (@(posedge clk) disable iff (rst)
        wr_val |-> !rd_val)
        else $error("write requested during a host read");

endmodule

//--- rtl/tcp_logger_pkg.sv
`include "tcp_logger_cfg.svh"

package tcp_logger_pkg;

    typedef logic [`TCP_LOGGER_FLIT_W-1:0] flit_t;
    typedef logic [7:0]                    node_id_t;
    typedef logic [7:0]                    flit_cnt_t;
    typedef logic [15:0]                   payload_len_t;
    typedef logic [31:0]                   tcp_seq_t;
    typedef logic [7:0]                    tcp_flags_t;

    typedef logic [`TCP_LOGGER_ADDR_W-1:0] log_addr_t;
    // one bit wider than the address so that a full log can be counted.
    typedef logic [`TCP_LOGGER_ADDR_W:0]   log_cnt_t;

    // first flit of a packet on the network.
    // msg_len counts the flits that follow the header.
    typedef struct packed {
        node_id_t   dst;
        node_id_t   src;
        flit_cnt_t  msg_len;
        logic [39:0] rsvd;
    } noc_hdr_t;

    // third flit of a packet, the start of the TCP header.
    typedef struct packed {
        tcp_seq_t   seq;
        tcp_flags_t flags;
        logic [23:0] other;
    } tcp_hdr_flit_t;

    // one entry of the log memory.
    typedef struct packed {
        node_id_t     src;
        tcp_seq_t     seq;
        tcp_flags_t   flags;
        payload_len_t payload_len;
    } log_record_t;

endpackage

//--- rtl/tcp_logger_record.sv
`timescale 1ns/1ns

module tcp_logger_record (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        in_val,
    output logic                        in_rdy,
    input  tcp_logger_pkg::flit_t       in_flit,

    output logic                        out_val,
    input  logic                        out_rdy,
    output tcp_logger_pkg::flit_t       out_flit,

    input  logic                        rd_val,
    input  tcp_logger_pkg::log_addr_t   rd_addr,
    output tcp_logger_pkg::log_record_t rd_data,
    output logic                        rd_data_val,

    output tcp_logger_pkg::log_cnt_t    log_count
);

    logic                        store_hdr;
    logic                        mod_hdr_flit;
    logic                        store_len;
    logic                        incr_num_flits;
    logic                        incr_addr;
    logic                        last_flit;
    logic                        log_full;
    logic                        wr_val;
    logic                        wr_rdy;
    tcp_logger_pkg::log_addr_t   wr_addr;
    tcp_logger_pkg::log_record_t wr_record;

    tcp_logger_record_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .in_val         (in_val),
        .in_rdy         (in_rdy),
        .out_val        (out_val),
        .out_rdy        (out_rdy),
        .wr_val         (wr_val),
        .wr_rdy         (wr_rdy),
        .store_hdr      (store_hdr),
        .mod_hdr_flit   (mod_hdr_flit),
        .store_len      (store_len),
        .incr_num_flits (incr_num_flits),
        .incr_addr      (incr_addr),
        .last_flit      (last_flit),
        .log_full       (log_full)
    );

    tcp_logger_record_datap i_datap (
        .clk            (clk),
        .rst            (rst),
        .in_flit        (in_flit),
        .out_flit       (out_flit),
        .store_hdr      (store_hdr),
        .mod_hdr_flit   (mod_hdr_flit),
        .store_len      (store_len),
        .incr_num_flits (incr_num_flits),
        .incr_addr      (incr_addr),
        .last_flit      (last_flit),
        .log_full       (log_full),
        .wr_addr        (wr_addr),
        .wr_record      (wr_record),
        .log_count      (log_count)
    );

    tcp_logger_mem i_mem (
        .clk         (clk),
        .rst         (rst),
        .wr_val      (wr_val),
        .wr_addr     (wr_addr),
        .wr_record   (wr_record),
        .wr_rdy      (wr_rdy),
        .rd_val      (rd_val),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_data_val (rd_data_val)
    );

endmodule

//--- rtl/tcp_logger_record_ctrl.sv
`timescale 1ns/1ns

module tcp_logger_record_ctrl (
    input  logic clk,
    input  logic rst,

    input  logic in_val,
    output logic in_rdy,

    output logic out_val,
    input  logic out_rdy,

    output logic wr_val,
    input  logic wr_rdy,

    output logic store_hdr,
    output logic mod_hdr_flit,
    output logic store_len,
    output logic incr_num_flits,
    output logic incr_addr,

    input  logic last_flit,
    input  logic log_full
);

    typedef enum logic [1:0] {
        READY     = 2'd0,
        PASS_META = 2'd1,
        GRAB_HDR  = 2'd2,
        PASS_DATA = 2'd3
    } state_e;

    state_e state_reg;
    state_e state_next;

    logic   xfer;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end else begin
            state_reg <= state_next;
        end
    end

    // handshake on the pass-through path. In GRAB_HDR the log memory must also accept.
    assign xfer = in_val & out_rdy & ((state_reg != GRAB_HDR) | wr_rdy);

    always_comb begin
        in_rdy         = 1'b0;
        out_val        = 1'b0;
        wr_val         = 1'b0;
        store_hdr      = 1'b0;
        mod_hdr_flit   = 1'b0;
        store_len      = 1'b0;
        incr_num_flits = 1'b0;
        incr_addr      = 1'b0;
        state_next     = state_reg;

        case (state_reg)
            READY: begin
                in_rdy       = out_rdy;
                out_val      = in_val;
                mod_hdr_flit = in_val;
                store_hdr    = 1'b1;
                if (xfer) begin
                    state_next = PASS_META;
                end
            end
            PASS_META: begin
                in_rdy  = out_rdy;
                out_val = in_val;
                if (xfer) begin
                    store_len      = 1'b1;
                    incr_num_flits = 1'b1;
                    state_next     = GRAB_HDR;
                end
            end
            GRAB_HDR: begin
                // a host read holds the TCP flit so that its record is not dropped.
                in_rdy  = out_rdy & wr_rdy;
                out_val = in_val & wr_rdy;
                if (xfer) begin
                    wr_val         = ~log_full;
                    incr_addr      = ~log_full;
                    incr_num_flits = 1'b1;
                    if (last_flit) begin
                        state_next = READY;
                    end else begin
                        state_next = PASS_DATA;
                    end
                end
            end
            PASS_DATA: begin
                in_rdy  = out_rdy;
                out_val = in_val;
                if (xfer) begin
                    incr_num_flits = 1'b1;
                    if (last_flit) begin
                        state_next = READY;
                    end
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

    // a TCP flit that is held back must stay offered until its record is written.
    property p_tcp_flit_held;
        @(posedge clk) disable iff (rst)
        (state_reg == GRAB_HDR && in_val && !in_rdy) |=> in_val;
    endproperty

    a_tcp_flit_held: assert property (p_tcp_flit_held)
        else $error("TCP flit withdrawn before its record was written");

endmodule

//--- rtl/tcp_logger_record_datap.sv
`timescale 1ns/1ns
`include "tcp_logger_cfg.svh"

module tcp_logger_record_datap (
    input  logic                       clk,
    input  logic                       rst,

    input  tcp_logger_pkg::flit_t      in_flit,
    output tcp_logger_pkg::flit_t      out_flit,

    input  logic                       store_hdr,
    input  logic                       mod_hdr_flit,
    input  logic                       store_len,
    input  logic                       incr_num_flits,
    input  logic                       incr_addr,

    output logic                       last_flit,
    output logic                       log_full,

    output tcp_logger_pkg::log_addr_t  wr_addr,
    output tcp_logger_pkg::log_record_t wr_record,
    output tcp_logger_pkg::log_cnt_t   log_count
);

    tcp_logger_pkg::noc_hdr_t      hdr_in;
    tcp_logger_pkg::noc_hdr_t      hdr_out;
    tcp_logger_pkg::tcp_hdr_flit_t tcp_flit;

    tcp_logger_pkg::node_id_t      src_reg;
    tcp_logger_pkg::flit_cnt_t     msg_len_reg;
    tcp_logger_pkg::payload_len_t  payload_len_reg;
    tcp_logger_pkg::flit_cnt_t     num_flits;
    tcp_logger_pkg::log_cnt_t      addr_cnt;

    assign hdr_in   = tcp_logger_pkg::noc_hdr_t'(in_flit);
    assign tcp_flit = tcp_logger_pkg::tcp_hdr_flit_t'(in_flit);

    always_comb begin
        hdr_out     = hdr_in;
        hdr_out.dst = `TCP_LOGGER_FWD_DST;
        hdr_out.src = `TCP_LOGGER_NODE_ID;
    end

    assign out_flit = mod_hdr_flit ? tcp_logger_pkg::flit_t'(hdr_out) : in_flit;

    // the header fields are taken every cycle in READY. The last load is the real header.
    always_ff @(posedge clk) begin
        if (store_hdr) begin
            src_reg     <= hdr_in.src;
            msg_len_reg <= hdr_in.msg_len;
        end
        if (store_len) begin
            payload_len_reg <= in_flit[`TCP_LOGGER_FLIT_W-1 -: 16];
        end
    end

    // num_flits holds how many flits after the header have already passed.
    always_ff @(posedge clk) begin
        if (rst || store_hdr) begin
            num_flits <= '0;
        end else if (incr_num_flits) begin
            num_flits <= num_flits + 8'd1;
        end
    end

    assign last_flit = (tcp_logger_pkg::flit_cnt_t'(num_flits + 8'd1) == msg_len_reg);

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_cnt <= '0;
        end else if (incr_addr && !log_full) begin
            addr_cnt <= addr_cnt + 1'b1;
        end
    end

    assign log_full  = (addr_cnt == tcp_logger_pkg::log_cnt_t'(`TCP_LOGGER_LOG_DEPTH));
    assign wr_addr   = addr_cnt[`TCP_LOGGER_ADDR_W-1:0];
    assign log_count = addr_cnt;

    always_comb begin
        wr_record.src         = src_reg;
        wr_record.seq         = tcp_flit.seq;
        wr_record.flags       = tcp_flit.flags;
        wr_record.payload_len = payload_len_reg;
    end

    // packets with fewer than two flits after the header are not handled.
    a_msg_len_min: assert property (@(posedge clk) disable iff (rst)
        store_len |-> msg_len_reg >= 8'd2)
        else $error("packet shorter than three flits");

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f \
    --top-module tcp_logger_record_tb -o tcp_logger_sim &&
./obj_dir/tcp_logger_sim || exit 1

//--- tests/tcp_logger_record_tb.sv
`timescale 1ns/1ns
`include "tcp_logger_cfg.svh"

module tcp_logger_record_tb;

    localparam int NUM_PKTS       = 25;
    localparam int MAX_FLITS      = NUM_PKTS * 7;
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [1:0] K_HDR  = 2'd0;
    localparam logic [1:0] K_META = 2'd1;
    localparam logic [1:0] K_TCP  = 2'd2;
    localparam logic [1:0] K_DATA = 2'd3;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        in_val;
    logic                        in_rdy;
    tcp_logger_pkg::flit_t       in_flit;
    logic                        out_val;
    logic                        out_rdy;
    tcp_logger_pkg::flit_t       out_flit;
    logic                        rd_val;
    tcp_logger_pkg::log_addr_t   rd_addr;
    tcp_logger_pkg::log_record_t rd_data;
    logic                        rd_data_val;
    tcp_logger_pkg::log_cnt_t    log_count;

    tcp_logger_pkg::flit_t       in_flits  [MAX_FLITS];
    tcp_logger_pkg::flit_t       exp_flits [MAX_FLITS];
    logic [1:0]                  kinds     [MAX_FLITS];
    int                          pkt_first [NUM_PKTS];
    int                          pkt_flits [NUM_PKTS];
    tcp_logger_pkg::log_record_t model_log [`TCP_LOGGER_LOG_DEPTH];
    int                          n_flits;

    int                          in_idx;
    int                          out_idx;
    int                          cycles = 0;
    logic [1:0]                  in_kind;
    logic [1:0]                  out_kind;
    tcp_logger_pkg::flit_t       exp_cur;
    tcp_logger_pkg::flit_t       orig_cur;
    tcp_logger_pkg::log_addr_t   rd_addr_q;
    tcp_logger_pkg::log_record_t exp_rec;
    tcp_logger_pkg::log_cnt_t    exp_cnt;

    tcp_logger_record i_tcp_logger_record (
        .clk         (clk),
        .rst         (rst),
        .in_val      (in_val),
        .in_rdy      (in_rdy),
        .in_flit     (in_flit),
        .out_val     (out_val),
        .out_rdy     (out_rdy),
        .out_flit    (out_flit),
        .rd_val      (rd_val),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .rd_data_val (rd_data_val),
        .log_count   (log_count)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    // stream positions and the expected record count follow the handshakes.
    always_ff @(posedge clk) begin
        if (rst) begin
            in_idx  <= 0;
            out_idx <= 0;
            exp_cnt <= '0;
        end else begin
            if (in_val && in_rdy) begin
                in_idx <= in_idx + 1;
                if (in_kind == K_TCP && exp_cnt < 5'd16) begin
                    exp_cnt <= exp_cnt + 5'd1;
                end
            end
            if (out_val && out_rdy) begin
                out_idx <= out_idx + 1;
            end
        end
        rd_addr_q <= rd_addr;
    end

    always_comb begin
        in_kind  = (in_idx < n_flits) ? kinds[in_idx] : K_DATA;
        out_kind = (out_idx < n_flits) ? kinds[out_idx] : K_DATA;
        exp_cur  = (out_idx < n_flits) ? exp_flits[out_idx] : '0;
        orig_cur = (out_idx < n_flits) ? in_flits[out_idx] : '0;
        exp_rec  = model_log[rd_addr_q];
    end

    task automatic report_mismatch(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    a_same_cycle: assert property (@(posedge clk) disable iff (rst)
        (in_val && in_rdy) == (out_val && out_rdy))
        else report_mismatch("input and output handshakes differ");
    a_flit_order: assert property (@(posedge clk) disable iff (rst)
        (out_val && out_rdy) |-> (out_idx < n_flits && out_flit == exp_cur))
        else report_mismatch("output flit does not match the expected flit");
    a_hdr_rewrite: assert property (@(posedge clk) disable iff (rst)
        (out_val && out_rdy && out_kind == K_HDR) |->
            (out_flit[63:56] == `TCP_LOGGER_FWD_DST && out_flit[55:48] == `TCP_LOGGER_NODE_ID
             && out_flit[47:40] == orig_cur[47:40]))
        else report_mismatch("header fields not rewritten as expected");
    a_rd_latency: assert property (@(posedge clk) disable iff (rst)
        rd_val |=> rd_data_val)
        else report_mismatch("rd_data_val missing one cycle after rd_val");
    a_rd_no_extra: assert property (@(posedge clk) disable iff (rst)
        !rd_val |=> !rd_data_val)
        else report_mismatch("rd_data_val without a read");
    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        rd_data_val |-> (rd_data == exp_rec))
        else report_mismatch("log record differs from the model");
    a_log_count: assert property (@(posedge clk) disable iff (rst)
        log_count == exp_cnt)
        else report_mismatch("log_count differs from the expected count");
    a_tcp_held: assert property (@(posedge clk) disable iff (rst)
        (rd_val && in_val && in_kind == K_TCP) |-> (!in_rdy && !out_val))
        else report_mismatch("TCP flit moved during a host read");

    task automatic add_flit(input tcp_logger_pkg::flit_t flit,
                            input tcp_logger_pkg::flit_t exp,
                            input logic [1:0] kind);
        in_flits[n_flits]  = flit;
        exp_flits[n_flits] = exp;
        kinds[n_flits]     = kind;
        n_flits++;
    endtask

    task automatic build_packets();
        logic [63:0]                  rnd;
        tcp_logger_pkg::flit_cnt_t    msg_len;
        tcp_logger_pkg::node_id_t     src;
        tcp_logger_pkg::payload_len_t plen;
        tcp_logger_pkg::tcp_seq_t     seq;
        tcp_logger_pkg::tcp_flags_t   flags;
        n_flits = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            // every fifth packet ends right at its TCP flit.
            msg_len = (p % 5 == 0) ? 8'd2 : 8'($urandom_range(6, 2));
            rnd     = {$urandom, $urandom};
            src     = rnd[55:48];
            pkt_first[p] = n_flits;
            pkt_flits[p] = int'(msg_len) + 1;
            add_flit({rnd[63:56], src, msg_len, rnd[39:0]},
                     {`TCP_LOGGER_FWD_DST, `TCP_LOGGER_NODE_ID, msg_len, rnd[39:0]}, K_HDR);
            rnd  = {$urandom, $urandom};
            plen = rnd[63:48];
            add_flit(rnd, rnd, K_META);
            rnd   = {$urandom, $urandom};
            seq   = rnd[63:32];
            flags = rnd[31:24];
            add_flit(rnd, rnd, K_TCP);
            if (p < `TCP_LOGGER_LOG_DEPTH) begin
                model_log[p] = {src, seq, flags, plen};
            end
            for (int d = 2; d < int'(msg_len); d++) begin
                rnd = {$urandom, $urandom};
                add_flit(rnd, rnd, K_DATA);
            end
        end
    endtask

    task automatic send_flit(input int idx, input bit read_first);
        bit first;
        first   = 1'b1;
        in_val  = 1'b1;
        in_flit = in_flits[idx];
        while (in_idx == idx) begin
            if (first && read_first) begin
                rd_val  = 1'b1;
                rd_addr = '0;
                out_rdy = 1'b1;
            end else begin
                rd_val  = 1'b0;
                out_rdy = ($urandom_range(99) >= 30);
            end
            first = 1'b0;
            @(posedge clk);
            #2;
        end
        rd_val = 1'b0;
    endtask

    task automatic read_log(input int count);
        in_val = 1'b0;
        for (int a = 0; a < count; a++) begin
            rd_val  = 1'b1;
            rd_addr = tcp_logger_pkg::log_addr_t'(a);
            @(posedge clk);
            #2;
        end
        rd_val = 1'b0;
        @(posedge clk);
        #2;
    endtask

    initial begin
        bit hold_read;
        void'($urandom(32'hea0081c4));
        rst      = 1'b1;
        in_val   = 1'b0;
        in_flit  = '0;
        out_rdy  = 1'b0;
        rd_val   = 1'b0;
        rd_addr  = '0;
        build_packets();
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int p = 0; p < NUM_PKTS; p++) begin
            for (int f = 0; f < pkt_flits[p]; f++) begin
                hold_read = (f == 2) && (p % 4 == 3) && (log_count != '0);
                send_flit(pkt_first[p] + f, hold_read);
            end
            read_log(int'(log_count));
        end
        read_log(`TCP_LOGGER_LOG_DEPTH);
        @(posedge clk);
        #2;
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/tcp_logger_pkg.sv
rtl/tcp_logger_record_ctrl.sv
rtl/tcp_logger_record_datap.sv
rtl/tcp_logger_mem.sv
rtl/tcp_logger_record.sv
tests/tcp_logger_record_tb.sv
